// ==== dv/ex_stage_patterns.txt ====
# P rd data | S cycles rd data | F
# I/T op asel bsel rs1 rs2 rd imm btype flags fwd fdata pc port brj taken (hex)
# flags b0 shamt_sel b1 branch b2 jump b3 j_sel b4 ex_pc_sel b5 wen b6 dren b7 dwen b8 illegal
P 01 00000007
P 02 00000005
P 03 ffffff80
P 06 00000010
P 00 deadbeef
I 0 0 1 01 02 07 00000000 0 020 0 00000000 00001000 0000000c 00001004 0
I 1 0 1 02 01 08 00000000 0 020 0 00000000 00001004 fffffffe 00001008 0
I 7 0 2 03 00 09 00000002 0 021 0 00000000 00001008 ffffffe0 0000100c 0
I 8 0 1 03 02 0a 00000000 0 020 0 00000000 0000100c 00000001 00001010 0
I 9 0 1 03 02 0b 00000000 0 020 0 00000000 00001010 00000000 00001014 0
I 0 3 3 00 00 0c abcde000 0 020 0 00000000 00001014 abcde000 00001018 0
I 0 0 1 00 02 0d 00000000 0 020 0 00000000 00001018 00000005 0000101c 0
I 0 0 1 01 02 0e 00000000 0 020 1 00000100 0000101c 00000105 00001020 0
I 0 0 1 01 01 00 00000010 0 002 0 00000000 00001100 0000000e 00001110 1
I 0 0 1 01 02 00 00000010 0 002 0 00000000 00001104 0000000c 00001108 0
I 0 0 1 02 03 00 00001ff0 6 002 0 00000000 00001200 ffffff85 000011f0 1
I 0 0 1 03 02 00 00001ff0 6 002 0 00000000 00001204 ffffff85 00001208 0
I 0 3 2 00 00 01 00000404 0 03c 0 00000000 00001300 00000404 00001704 0
I 0 0 2 06 00 01 00000fff 0 034 0 00000000 00001400 0000000f 0000000e 0
T 0 1 0 06 09 00 00000008 0 080 0 00000000 00001500 00000018 00001504 0
T 0 1 0 06 09 00 0000000c 0 080 2 00000000 00001504 0000001c 00001508 0
I 0 0 1 01 02 05 00000000 0 1a0 0 00000000 00001600 0000000c 00001604 0
S 3 02 12345678
I 0 0 1 00 02 0f 00000000 0 020 0 00000000 00001700 00000005 00001704 0
F

// ==== tb.f ====
+incdir+src
src/ex_isa_pkg.sv
src/ex_pipe_pkg.sv
src/reg_file.sv
src/alu.sv
src/branch_jump_unit.sv
src/ex_ctrl.sv
src/ex_stage.sv
dv/tb_clk_gen.sv
dv/ex_stage_asserts.sv
dv/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module ex_stage_tb \
    && ./obj_dir/Vex_stage_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

// ==== dv/ex_stage_tb.sv ====
// testbench top with pattern reader, input drivers and EX/MEM result checks
`timescale 1ns/1ps
`include "rv_consts.svh"

module ex_stage_tb;

    localparam string PATTERN_FILE = "dv/ex_stage_patterns.txt";

    logic                   CLK;
    logic                   nRST;
    ex_pipe_pkg::ex_uop_t   uop;
    logic                   stall;
    logic                   flush;
    ex_pipe_pkg::wb_port_t  wb;
    ex_pipe_pkg::fwd_port_t fwd;
    ex_pipe_pkg::ex_mem_t   ex_mem;

    // bookkeeping
    int          tests = 0;
    int          failed_tests = 0;
    int          test_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 50;
    int          lines;
    int          fd;
    string       line;
    logic [31:0] rng_state;

    tb_clk_gen u_clk_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    ex_stage DUT (
        .CLK    (CLK),
        .nRST   (nRST),
        .uop    (uop),
        .stall  (stall),
        .flush  (flush),
        .wb     (wb),
        .fwd    (fwd),
        .ex_mem (ex_mem)
    );

    bind ex_stage ex_stage_asserts u_asserts (
        .CLK    (CLK),
        .nRST   (nRST),
        .stall  (stall),
        .flush  (flush),
        .ex_mem (ex_mem)
    );

    // LCG step
    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic drive_idle();
        uop   = '0;
        stall = 1'b0;
        flush = 1'b0;
        wb    = '0;
        fwd   = '0;
    endtask

    task automatic check_word(input string what, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            test_errors++;
        end
    endtask

    // one result line per test
    task automatic finish_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d check(s) failed", tests, name, test_errors);
            failed_tests++;
        end
        test_errors = 0;
    endtask

    task automatic report_bad_line(input string text);
        $display("malformed pattern line could not be parsed: %s", text);
        failed_tests++;
    endtask

    task automatic count_pattern_lines(output int count);
        int    cfd;
        string cline;
        count = 0;
        cfd = $fopen(PATTERN_FILE, "r");
        if (cfd != 0) begin
            while ($fgets(cline, cfd) != 0) begin
                if (cline.len() > 0 && cline[0] != "#") begin
                    count++;
                end
            end
            $fclose(cfd);
        end
    endtask

    // writeback port write that lands at the next rising edge
    task automatic write_register(input logic [`REG_IDX_W-1:0] rd, input logic [31:0] data);
        drive_idle();
        wb.wen   = 1'b1;
        wb.rd    = rd;
        wb.wdata = data;
        @(negedge CLK);
        wb = '0;
    endtask

    task automatic check_reset();
        check_bit("valid", ex_mem.valid, 1'b0);
        check_bit("reg_write", ex_mem.reg_write, 1'b0);
        check_bit("dren", ex_mem.dren, 1'b0);
        check_bit("dwen", ex_mem.dwen, 1'b0);
        check_bit("halt", ex_mem.halt, 1'b0);
        finish_test("reset");
    endtask

    task automatic run_preload(input string text);
        logic [7:0]  kind;
        logic [31:0] rd;
        logic [31:0] data;
        if ($sscanf(text, "%c %h %h", kind, rd, data) != 3) begin
            report_bad_line(text);
        end else begin
            write_register(rd[4:0], data);
        end
    endtask

    // instruction line
    // store lines use random rs2 data
    task automatic run_instr(input string text, input logic is_store);
        logic [7:0]  kind;
        logic [31:0] op, as, bs, r1, r2, rd, imm, bt, flags;
        logic [31:0] fw, fdata, pc, port, brj, tk;
        logic [31:0] rdata;
        logic        ill;
        if ($sscanf(text, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    kind, op, as, bs, r1, r2, rd, imm, bt, flags,
                    fw, fdata, pc, port, brj, tk) != 16) begin
            report_bad_line(text);
        end else begin
            rdata = '0;
            if (is_store) begin
                rng_state = next_random(rng_state);
                rdata     = rng_state;
                if (fw[1]) begin
                    fdata = rdata;
                end else begin
                    write_register(r2[4:0], rdata);
                end
            end
            drive_idle();
            uop.valid         = 1'b1;
            uop.pc            = pc;
            uop.pc4           = pc + 32'd4;
            // tag word so the instr field is traceable
            uop.instr         = pc ^ imm;
            uop.rs1           = r1[4:0];
            uop.rs2           = r2[4:0];
            uop.rd            = rd[4:0];
            uop.imm_I         = imm[11:0];
            uop.imm_S         = imm[11:0];
            uop.imm_SB        = imm[12:0];
            uop.imm_UJ        = imm[20:0];
            uop.imm_U         = imm;
            uop.shamt         = imm[4:0];
            uop.imm_shamt_sel = flags[0];
            uop.alu_op        = ex_isa_pkg::alu_op_e'(op[3:0]);
            uop.a_sel         = ex_isa_pkg::a_sel_e'(as[1:0]);
            uop.b_sel         = ex_isa_pkg::b_sel_e'(bs[1:0]);
            uop.branch        = flags[1];
            uop.branch_type   = ex_isa_pkg::branch_e'(bt[2:0]);
            uop.jump          = flags[2];
            uop.j_sel         = flags[3];
            uop.ex_pc_sel     = flags[4];
            uop.wen           = flags[5];
            uop.dren          = flags[6];
            uop.dwen          = flags[7];
            uop.illegal       = flags[8];
            // an illegal uop also requests halt so the squash covers it
            uop.halt          = flags[8];
            fwd.fwd_rs1       = fw[0];
            fwd.fwd_rs2       = fw[1];
            fwd.data          = fdata;
            @(negedge CLK);
            // illegal squashes every side effect but keeps the fault
            ill = flags[8];
            check_bit("valid", ex_mem.valid, 1'b1);
            check_bit("illegal", ex_mem.illegal, ill);
            check_bit("reg_write", ex_mem.reg_write, flags[5] & ~ill);
            check_bit("dren", ex_mem.dren, flags[6] & ~ill);
            check_bit("dwen", ex_mem.dwen, flags[7] & ~ill);
            check_bit("branch", ex_mem.branch, flags[1] & ~ill);
            check_bit("jump", ex_mem.jump, flags[2] & ~ill);
            check_bit("halt", ex_mem.halt, flags[8] & ~ill);
            check_bit("branch_taken", ex_mem.branch_taken, tk[0]);
            check_word("rd", 32'(ex_mem.rd), rd);
            check_word("pc", ex_mem.pc, pc);
            check_word("pc4", ex_mem.pc4, pc + 32'd4);
            check_word("instr", ex_mem.instr, pc ^ imm);
            check_word("port_out", ex_mem.port_out, port);
            check_word("brj_addr", ex_mem.brj_addr, brj);
            if (is_store) begin
                check_word("rs2_data", ex_mem.rs2_data, rdata);
            end
            finish_test($sformatf("%s pc=%h", is_store ? "store" : "instr", pc));
        end
    endtask

    // stall with flush and a writeback that must all be ignored
    task automatic run_stall(input string text);
        logic [7:0]           kind;
        logic [31:0]          n;
        logic [31:0]          rd;
        logic [31:0]          data;
        ex_pipe_pkg::ex_mem_t held;
        if ($sscanf(text, "%c %h %h %h", kind, n, rd, data) != 4) begin
            report_bad_line(text);
        end else begin
            held = ex_mem;
            drive_idle();
            uop.valid = 1'b1;
            uop.wen   = 1'b1;
            uop.pc    = 32'hffff_0000;
            stall     = 1'b1;
            flush     = 1'b1;
            wb.wen    = 1'b1;
            wb.rd     = rd[4:0];
            wb.wdata  = data;
            repeat (n[3:0]) begin
                @(negedge CLK);
                assert (ex_mem === held) else begin
                    $display("CHECK FAILED at %0t ns: ex_mem changed during stall", $time);
                    test_errors++;
                end
            end
            drive_idle();
            finish_test($sformatf("stall %0d cycles", n));
        end
    endtask

    task automatic run_flush();
        drive_idle();
        uop.valid = 1'b1;
        uop.wen   = 1'b1;
        uop.pc    = 32'h0000_2000;
        flush     = 1'b1;
        @(negedge CLK);
        assert (ex_mem === '0) else begin
            $display("CHECK FAILED at %0t ns: ex_mem not cleared by flush", $time);
            test_errors++;
        end
        drive_idle();
        finish_test("flush");
    endtask

    task automatic run_line(input string text);
        logic [7:0] kind;
        if ($sscanf(text, "%c", kind) == 1) begin
            case (kind)
                "P":     run_preload(text);
                "I":     run_instr(text, 1'b0);
                "T":     run_instr(text, 1'b1);
                "S":     run_stall(text);
                "F":     run_flush();
                // comments and blank lines
                default: ;
            endcase
        end
    endtask

    // run limit
    always @(posedge CLK) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        drive_idle();
        rng_state = 32'h7b82b1be;
        count_pattern_lines(lines);
        cycle_limit = lines * 4 + 50;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("pattern file %s could not be opened", PATTERN_FILE);
            failed_tests++;
        end else begin
            wait (nRST === 1'b1);
            check_reset();
            while ($fgets(line, fd) != 0) begin
                run_line(line);
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d failed", tests, failed_tests);
        if (failed_tests == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/ex_stage_asserts.sv ====
// concurrent assertions on EX/MEM hold, flush and reset behavior
`timescale 1ns/1ps

module ex_stage_asserts (
    input logic                 CLK,
    input logic                 nRST,
    input logic                 stall,
    input logic                 flush,
    input ex_pipe_pkg::ex_mem_t ex_mem
);

    // stalled edge leaves the register untouched
    hold_on_stall: assert property (
        @(posedge CLK) disable iff (!nRST) stall |=> $stable(ex_mem)
    ) else $error("ex_mem changed across a stalled clock edge");

    // unstalled flush inserts a bubble
    bubble_on_flush: assert property (
        @(posedge CLK) disable iff (!nRST) (flush && !stall) |=> !ex_mem.valid
    ) else $error("ex_mem.valid still set after an unstalled flush");

    // first edge out of reset sees an empty register
    empty_after_reset: assert property (
        @(posedge CLK) $rose(nRST) |-> (!ex_mem.valid && !ex_mem.reg_write
            && !ex_mem.dren && !ex_mem.dwen && !ex_mem.jump
            && !ex_mem.branch && !ex_mem.halt)
    ) else $error("ex_mem control bits not cleared by reset");

endmodule

// ==== dv/tb_clk_gen.sv ====
// testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clk_gen (
    output logic CLK,
    output logic nRST
);

    // 10 ns period
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // reset low for 10 cycles, released on a falling edge
    initial begin
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

// ==== src/ex_stage.sv ====
// execute stage top with register file, ALU, branch unit and EX/MEM control
`timescale 1ns/1ps
`include "rv_consts.svh"

module ex_stage (
    input  logic                    CLK,
    input  logic                    nRST,
    input  ex_pipe_pkg::ex_uop_t    uop,
    input  logic                    stall,
    input  logic                    flush,
    input  ex_pipe_pkg::wb_port_t   wb,
    input  ex_pipe_pkg::fwd_port_t  fwd,
    output ex_pipe_pkg::ex_mem_t    ex_mem
);

    // operands after forwarding
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] port_out;
    logic [`XLEN-1:0] brj_addr;
    logic             branch_taken;
    // stall-gated write enable
    logic             rf_wen;

    // read ports from the uop, write port from writeback
    reg_file u_reg_file (
        .CLK     (CLK),
        .nRST    (nRST),
        .rs1     (uop.rs1),
        .rs2     (uop.rs2),
        .rd      (wb.rd),
        .wdata   (wb.wdata),
        .wen     (rf_wen),
        .fwd     (fwd),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    alu u_alu (
        .uop      (uop),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .port_out (port_out)
    );

    branch_jump_unit u_branch_jump_unit (
        .uop          (uop),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .branch_taken (branch_taken),
        .brj_addr     (brj_addr)
    );

    // owns the EX/MEM register
    ex_ctrl u_ex_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .uop          (uop),
        .stall        (stall),
        .flush        (flush),
        .wb_wen       (wb.wen),
        .branch_taken (branch_taken),
        .brj_addr     (brj_addr),
        .port_out     (port_out),
        .rs2_val      (rs2_val),
        .rf_wen       (rf_wen),
        .ex_mem       (ex_mem)
    );

endmodule

// ==== src/ex_ctrl.sv ====
// EX/MEM register control, illegal instruction squash, register write enable
`timescale 1ns/1ps
`include "rv_consts.svh"

module ex_ctrl (
    input  logic                    CLK,
    input  logic                    nRST,
    input  ex_pipe_pkg::ex_uop_t    uop,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    wb_wen,
    input  logic                    branch_taken,
    input  logic [`XLEN-1:0]        brj_addr,
    input  logic [`XLEN-1:0]        port_out,
    input  logic [`XLEN-1:0]        rs2_val,
    output logic                    rf_wen,
    output ex_pipe_pkg::ex_mem_t    ex_mem
);

    ex_pipe_pkg::ex_ctrl_t ctrl;
    ex_pipe_pkg::ex_mem_t  ex_mem_d;

    // squash side effects of an illegal instruction
    // valid and illegal still pass to record the fault
    always_comb begin
        ctrl         = '0;
        ctrl.valid   = uop.valid;
        ctrl.illegal = uop.illegal;
        if (!uop.illegal) begin
            ctrl.branch       = uop.branch;
            ctrl.branch_taken = uop.branch & branch_taken;
            ctrl.jump         = uop.jump;
            ctrl.reg_write    = uop.wen;
            ctrl.dren         = uop.dren;
            ctrl.dwen         = uop.dwen;
            ctrl.halt         = uop.halt;
        end
    end

    // next EX/MEM contents
    always_comb begin
        ex_mem_d.valid        = ctrl.valid;
        ex_mem_d.branch       = ctrl.branch;
        ex_mem_d.branch_taken = ctrl.branch_taken;
        ex_mem_d.jump         = ctrl.jump;
        ex_mem_d.reg_write    = ctrl.reg_write;
        ex_mem_d.dren         = ctrl.dren;
        ex_mem_d.dwen         = ctrl.dwen;
        ex_mem_d.halt         = ctrl.halt;
        ex_mem_d.illegal      = ctrl.illegal;
        ex_mem_d.rd           = uop.rd;
        ex_mem_d.instr        = uop.instr;
        ex_mem_d.pc           = uop.pc;
        ex_mem_d.pc4          = uop.pc4;
        ex_mem_d.brj_addr     = brj_addr;
        ex_mem_d.port_out     = port_out;
        // store data, post forwarding
        ex_mem_d.rs2_data     = rs2_val;
    end

    // stall holds over flush
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_mem <= '0;
        end else if (!stall) begin
            if (flush) begin
                ex_mem <= '0;
            end else begin
                ex_mem <= ex_mem_d;
            end
        end
    end

    // writeback dropped while stalled
    assign rf_wen = wb_wen & ~stall;

endmodule

// ==== src/branch_jump_unit.sv ====
// branch compare, branch and jump targets, next-PC select
`timescale 1ns/1ps
`include "rv_consts.svh"

module branch_jump_unit (
    input  ex_pipe_pkg::ex_uop_t    uop,
    input  logic [`XLEN-1:0]        rs1_val,
    input  logic [`XLEN-1:0]        rs2_val,
    output logic                    branch_taken,
    output logic [`XLEN-1:0]        brj_addr
);

    logic [`XLEN-1:0] branch_addr;
    logic [`XLEN-1:0] jal_addr;
    logic [`XLEN-1:0] jalr_addr;
    logic [`XLEN-1:0] jump_addr;

    // condition per funct3
    always_comb begin
        case (uop.branch_type)
            ex_isa_pkg::BR_BEQ:  branch_taken = (rs1_val == rs2_val);
            ex_isa_pkg::BR_BNE:  branch_taken = (rs1_val != rs2_val);
            ex_isa_pkg::BR_BLT:  branch_taken = ($signed(rs1_val) < $signed(rs2_val));
            ex_isa_pkg::BR_BGE:  branch_taken = ($signed(rs1_val) >= $signed(rs2_val));
            ex_isa_pkg::BR_BLTU: branch_taken = (rs1_val < rs2_val);
            ex_isa_pkg::BR_BGEU: branch_taken = (rs1_val >= rs2_val);
            default:             branch_taken = 1'b0;
        endcase
    end

    // pc-relative targets
    assign branch_addr = uop.pc + {{(`XLEN-13){uop.imm_SB[12]}}, uop.imm_SB};
    assign jal_addr    = uop.pc + {{(`XLEN-21){uop.imm_UJ[20]}}, uop.imm_UJ};

    // register-relative target, bit 0 cleared
    assign jalr_addr = (rs1_val + {{(`XLEN-12){uop.imm_I[11]}}, uop.imm_I})
                       & ~`XLEN'(1);

    // j_sel picks JAL over JALR
    assign jump_addr = uop.j_sel ? jal_addr : jalr_addr;

    // not-taken or non-branch falls through to pc4
    assign brj_addr = uop.ex_pc_sel ? jump_addr
                    : ((uop.branch && branch_taken) ? branch_addr : uop.pc4);

endmodule

// ==== src/alu.sv ====
// immediate extension, ALU operand select and integer ALU
`timescale 1ns/1ps
`include "rv_consts.svh"

module alu (
    input  ex_pipe_pkg::ex_uop_t    uop,
    input  logic [`XLEN-1:0]        rs1_val,
    input  logic [`XLEN-1:0]        rs2_val,
    output logic [`XLEN-1:0]        port_out
);

    logic [`XLEN-1:0]       imm_I_ext;
    logic [`XLEN-1:0]       imm_S_ext;
    logic [`XLEN-1:0]       imm_or_shamt;
    logic [`XLEN-1:0]       port_a;
    logic [`XLEN-1:0]       port_b;
    logic [`SHAMT_W-1:0]    sh;

    // sign extension of 12-bit immediates
    assign imm_I_ext = {{(`XLEN-12){uop.imm_I[11]}}, uop.imm_I};
    assign imm_S_ext = {{(`XLEN-12){uop.imm_S[11]}}, uop.imm_S};

    // shift immediates use shamt, zero extended
    assign imm_or_shamt = uop.imm_shamt_sel ? {{(`XLEN-`SHAMT_W){1'b0}}, uop.shamt}
                                            : imm_I_ext;

    // port A
    always_comb begin
        case (uop.a_sel)
            ex_isa_pkg::A_RS1:   port_a = rs1_val;
            ex_isa_pkg::A_IMM_S: port_a = imm_S_ext;
            ex_isa_pkg::A_PC:    port_a = uop.pc;
            default:             port_a = '0;
        endcase
    end

    // port B
    always_comb begin
        case (uop.b_sel)
            ex_isa_pkg::B_RS1:   port_b = rs1_val;
            ex_isa_pkg::B_RS2:   port_b = rs2_val;
            ex_isa_pkg::B_IMM_I: port_b = imm_or_shamt;
            default:             port_b = uop.imm_U;
        endcase
    end

    // only the low bits shift
    assign sh = port_b[`SHAMT_W-1:0];

    always_comb begin
        case (uop.alu_op)
            ex_isa_pkg::ALU_ADD:  port_out = port_a + port_b;
            ex_isa_pkg::ALU_SUB:  port_out = port_a - port_b;
            ex_isa_pkg::ALU_AND:  port_out = port_a & port_b;
            ex_isa_pkg::ALU_OR:   port_out = port_a | port_b;
            ex_isa_pkg::ALU_XOR:  port_out = port_a ^ port_b;
            ex_isa_pkg::ALU_SLL:  port_out = port_a << sh;
            ex_isa_pkg::ALU_SRL:  port_out = port_a >> sh;
            ex_isa_pkg::ALU_SRA:  port_out = $signed(port_a) >>> sh;
            // set-less-than gives 0 or 1
            ex_isa_pkg::ALU_SLT:  port_out = {{(`XLEN-1){1'b0}},
                                              $signed(port_a) < $signed(port_b)};
            ex_isa_pkg::ALU_SLTU: port_out = {{(`XLEN-1){1'b0}}, port_a < port_b};
            default:              port_out = '0;
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
// integer register file with writeback port and forwarded read outputs
`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_file (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic [`REG_IDX_W-1:0]   rs1,
    input  logic [`REG_IDX_W-1:0]   rs2,
    input  logic [`REG_IDX_W-1:0]   rd,
    input  logic [`XLEN-1:0]        wdata,
    input  logic                    wen,
    input  ex_pipe_pkg::fwd_port_t  fwd,
    output logic [`XLEN-1:0]        rs1_val,
    output logic [`XLEN-1:0]        rs2_val
);

    // writable entries x1 to x31 only
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];
    logic [`XLEN-1:0] rs1_stored;
    logic [`XLEN-1:0] rs2_stored;

    // write port drops x0 writes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '{default: '0};
        end else if (wen && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // combinational reads
    // no same-cycle write bypass
    // x0 reads as zero
    assign rs1_stored = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_stored = (rs2 == '0) ? '0 : regs[rs2];

    // memory stage data wins over stored value
    assign rs1_val = fwd.fwd_rs1 ? fwd.data : rs1_stored;
    assign rs2_val = fwd.fwd_rs2 ? fwd.data : rs2_stored;

endmodule

// ==== src/ex_pipe_pkg.sv ====
// packed structs for the decoded uop, writeback, forwarding and the EX/MEM register
`include "rv_consts.svh"

package ex_pipe_pkg;

    // one decoded instruction entering execute
    typedef struct packed {
        logic                       valid;
        logic [`XLEN-1:0]           pc;
        logic [`XLEN-1:0]           pc4;
        logic [`XLEN-1:0]           instr;
        // register indices
        logic [`REG_IDX_W-1:0]      rs1;
        logic [`REG_IDX_W-1:0]      rs2;
        logic [`REG_IDX_W-1:0]      rd;
        // raw immediates, extended in execute
        logic [11:0]                imm_I;
        logic [11:0]                imm_S;
        logic [12:0]                imm_SB;
        logic [20:0]                imm_UJ;
        // already shifted into the upper 20 bits
        logic [`XLEN-1:0]           imm_U;
        logic [`SHAMT_W-1:0]        shamt;
        logic                       imm_shamt_sel;
        // ALU control
        ex_isa_pkg::alu_op_e        alu_op;
        ex_isa_pkg::a_sel_e         a_sel;
        ex_isa_pkg::b_sel_e         b_sel;
        // control flow
        logic                       branch;
        ex_isa_pkg::branch_e        branch_type;
        logic                       jump;
        logic                       j_sel;
        logic                       ex_pc_sel;
        // side effects and faults
        logic                       wen;
        logic                       dren;
        logic                       dwen;
        logic                       halt;
        logic                       illegal;
    } ex_uop_t;

    // register write from writeback
    typedef struct packed {
        logic                       wen;
        logic [`REG_IDX_W-1:0]      rd;
        logic [`XLEN-1:0]           wdata;
    } wb_port_t;

    // memory stage forwarding
    typedef struct packed {
        logic                       fwd_rs1;
        logic                       fwd_rs2;
        logic [`XLEN-1:0]           data;
    } fwd_port_t;

    // control bits after illegal squash
    typedef struct packed {
        logic valid;
        logic branch;
        logic branch_taken;
        logic jump;
        logic reg_write;
        logic dren;
        logic dwen;
        logic halt;
        logic illegal;
    } ex_ctrl_t;

    // EX/MEM pipeline register
    typedef struct packed {
        logic                       valid;
        logic                       branch;
        logic                       branch_taken;
        logic                       jump;
        logic                       reg_write;
        logic                       dren;
        logic                       dwen;
        logic                       halt;
        logic                       illegal;
        logic [`REG_IDX_W-1:0]      rd;
        logic [`XLEN-1:0]           instr;
        logic [`XLEN-1:0]           pc;
        logic [`XLEN-1:0]           pc4;
        logic [`XLEN-1:0]           brj_addr;
        logic [`XLEN-1:0]           port_out;
        // store data
        logic [`XLEN-1:0]           rs2_data;
    } ex_mem_t;

endpackage

// ==== src/ex_isa_pkg.sv ====
// ISA enums for ALU operations, branch conditions and ALU operand selects
`include "rv_consts.svh"

package ex_isa_pkg;

    // integer ALU operations
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // branch conditions, same codes as funct3
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_e;

    // ALU port A source
    typedef enum logic [1:0] {
        A_RS1   = 2'd0,
        A_IMM_S = 2'd1,
        A_PC    = 2'd2,
        A_ZERO  = 2'd3
    } a_sel_e;

    // ALU port B source
    // B_IMM_I also covers shamt
    typedef enum logic [1:0] {
        B_RS1   = 2'd0,
        B_RS2   = 2'd1,
        B_IMM_I = 2'd2,
        B_IMM_U = 2'd3
    } b_sel_e;

endpackage

// ==== src/rv_consts.svh ====
// word width, register count, register index width and ALU opcode width
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath word, RV32I
`define XLEN 32

// architectural integer registers
`define REG_COUNT 32

// bits to address one register
`define REG_IDX_W 5

// ALU opcode field
`define ALU_OP_W 4

// shift amount field of a shift instruction
// low 5 bits of the operand on RV32
`define SHAMT_W 5

`endif
